//--- Bender.yml
package:
  name: mdom_slow_ctrl

export_include_dirs:
  - include

sources:
  - files:
      - hw/mdom_spi_pkg.sv
      - hw/spi_cmd_queue.sv
      - hw/spi_bus_arbiter.sv
      - hw/spi_shift_engine.sv
      - hw/mdom_slow_ctrl_top.sv
  - target: simulation
    files:
      - bench/mdom_spi_props.sv
      - bench/tb_mdom_slow_ctrl.sv

//--- bench/mdom_spi_props.sv
// ------------------------------------------------------------
// concurrent checks on chip selects, idle pins and readback
// bound into the slow-control top level
// ------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "mdom_spi_defs.svh"

module mdom_spi_props (
  input wire logic                    i_lclk,
  input wire logic                    i_lclk_rst,
  input wire mdom_spi_pkg::adc_pins_t i_adc_pins,
  input wire mdom_spi_pkg::dac_pins_t i_dac_pins,
  input wire logic                    i_adc_rsp_valid,
  input wire logic                    i_adc_rsp_ready,
  input wire mdom_spi_pkg::adc_rsp_t  i_adc_rsp
);
  import mdom_spi_pkg::*;

  logic adc_cs;
  logic dac_cs;

  assign adc_cs = !(&i_adc_pins.sen_n);
  assign dac_cs = !(&i_dac_pins.nsync_n);

  // selects released coming out of reset
  a_reset_idle: assert property (@(posedge i_lclk) i_lclk_rst |=> !adc_cs && !dac_cs)
    else $error("chip select active after reset");

  // shared engine, so never both ports at once
  a_one_port: assert property (@(posedge i_lclk) disable iff (i_lclk_rst) !(adc_cs && dac_cs))
    else $error("ADC and DAC selects active together");

  // unselected bus parks
  for (genvar b = 0; b < `MDOM_N_DAC_BUS; b++) begin : g_bus
    a_bus_idle: assert property (@(posedge i_lclk) disable iff (i_lclk_rst)
      (&i_dac_pins.nsync_n[b]) |-> (i_dac_pins.sclk[b] && !i_dac_pins.din[b]))
      else $error("idle DAC bus not parked");
  end

  a_rsp_hold: assert property (@(posedge i_lclk) disable iff (i_lclk_rst)
    (i_adc_rsp_valid && !i_adc_rsp_ready) |=> $stable(i_adc_rsp))
    else $error("readback changed while unread");

endmodule

bind mdom_slow_ctrl_top mdom_spi_props u_props (
  .i_lclk          (i_lclk),
  .i_lclk_rst      (i_lclk_rst),
  .i_adc_pins      (o_adc_pins),
  .i_dac_pins      (o_dac_pins),
  .i_adc_rsp_valid (o_adc_rsp_valid),
  .i_adc_rsp_ready (i_adc_rsp_ready),
  .i_adc_rsp       (o_adc_rsp)
);

`default_nettype wire

//--- bench/tb_mdom_slow_ctrl.sv
// ------------------------------------------------------------
// testbench for the slow-control SPI top level
// ADC and DAC device models, reference predictions, compares
// ------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "mdom_spi_defs.svh"

module tb_mdom_slow_ctrl;
  import mdom_spi_pkg::*;

  localparam int WAIT_LIMIT = 4000;
  localparam int ADC_LEN = `MDOM_SPI_LEAD + 2 * `MDOM_SPI_HALF * `MDOM_ADC_BITS + `MDOM_SPI_TAIL;
  localparam int DAC_LEN = `MDOM_SPI_LEAD + 2 * `MDOM_SPI_HALF * `MDOM_DAC_BITS + `MDOM_SPI_TAIL;

  logic      lclk;
  logic      lclk_rst;
  logic      adc_cmd_valid;
  logic      adc_cmd_ready;
  adc_cmd_t  adc_cmd;
  logic      dac_cmd_valid;
  logic      dac_cmd_ready;
  dac_cmd_t  dac_cmd;
  logic      adc_rsp_valid;
  logic      adc_rsp_ready;
  adc_rsp_t  adc_rsp;
  adc_pins_t adc_pins;
  logic      adc_sdout;
  dac_pins_t dac_pins;

  logic [31:0] lfsr_q = 32'hcb108110;
  // expected traffic, filled by the stimulus
  adc_cmd_t    adc_exp_q[$];
  dac_cmd_t    dac_exp_q[$];
  logic [23:0] dev_word_q[$];
  adc_rsp_t    rsp_exp_q[$];
  // model state
  logic        adc_cs_d;
  logic        adc_sclk_d;
  logic [23:0] dev_word;
  logic [23:0] adc_cap;
  adc_cmd_t    adc_obs;
  int          adc_bit;
  int          adc_rises;
  int          adc_len;
  logic        dac_cs_d;
  logic [`MDOM_N_DAC_BUS-1:0] dac_sclk_d;
  logic [31:0] dac_cap[`MDOM_N_DAC_BUS];
  int          dac_falls[`MDOM_N_DAC_BUS];
  dac_cmd_t    dac_obs;
  int          dac_len;
  // order and back-pressure checks
  logic        check_order;
  logic        hold_adc;
  spi_owner_e  last_owner;
  logic        owner_seen;

  mdom_slow_ctrl_top i_dut (
    .i_lclk          (lclk),
    .i_lclk_rst      (lclk_rst),
    .i_adc_cmd_valid (adc_cmd_valid),
    .o_adc_cmd_ready (adc_cmd_ready),
    .i_adc_cmd       (adc_cmd),
    .i_dac_cmd_valid (dac_cmd_valid),
    .o_dac_cmd_ready (dac_cmd_ready),
    .i_dac_cmd       (dac_cmd),
    .o_adc_rsp_valid (adc_rsp_valid),
    .i_adc_rsp_ready (adc_rsp_ready),
    .o_adc_rsp       (adc_rsp),
    .o_adc_pins      (adc_pins),
    .i_adc_sdout     (adc_sdout),
    .o_dac_pins      (dac_pins)
  );

  initial lclk = 1'b0;
  always #2 lclk = ~lclk;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1);
  endtask

  // galois lfsr, one step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'ha3000000) : (lfsr_q >> 1);
    end
    return v;
  endfunction

  // wire view of an ADC write, word MSB first on sdata
  function automatic adc_cmd_t predict_adc_frame(input adc_cmd_t c);
    adc_cmd_t p;
    p.sel  = c.sel;
    p.word = c.word;
    return p;
  endfunction

  function automatic dac_cmd_t predict_dac_frame(input dac_cmd_t c);
    dac_cmd_t p;
    p.bus_sel  = c.bus_sel;
    p.chip_sel = c.chip_sel;
    p.word     = c.word;
    return p;
  endfunction

  // readback is the last byte the ADC shifts out
  function automatic adc_rsp_t predict_rsp(input logic [23:0] w);
    adc_rsp_t r;
    r.rd_byte = w[7:0];
    return r;
  endfunction

  task automatic check_adc_frame(input adc_cmd_t got, input adc_cmd_t exp);
    if (got !== exp) begin
      $display("FAILED o_adc_pins frame: got %h expected %h", got, exp);
      abort_run("ADC frame mismatch");
    end
  endtask

  task automatic check_dac_frame(input dac_cmd_t got, input dac_cmd_t exp);
    if (got !== exp) begin
      $display("FAILED o_dac_pins frame: got %h expected %h", got, exp);
      abort_run("DAC frame mismatch");
    end
  endtask

  task automatic check_adc_rsp(input adc_rsp_t got, input adc_rsp_t exp);
    if (got !== exp) begin
      $display("FAILED o_adc_rsp: got %h expected %h", got, exp);
      abort_run("readback mismatch");
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("FAILED %s: got %h expected %h", name, got, exp);
      abort_run("frame timing mismatch");
    end
  endtask

  task automatic note_owner(input spi_owner_e o);
    if (check_order && owner_seen && last_owner == o) begin
      abort_run("arbiter granted the same port twice while both had work");
    end
    if (check_order && !owner_seen && o != OWNER_ADC) begin
      abort_run("first grant after reset did not go to the ADC");
    end
    last_owner = o;
    owner_seen = 1'b1;
  endtask

  // ADC device model, sampled mid-cycle
  always @(negedge lclk) begin
    if (lclk_rst) begin
      adc_cs_d   <= 1'b0;
      adc_sclk_d <= 1'b0;
      adc_sdout  <= 1'b0;
    end else begin
      if (adc_cs_d === 1'b0 && !(&adc_pins.sen_n)) begin
        if (hold_adc) abort_run("ADC frame started while readback was unread");
        if (dev_word_q.size() == 0) abort_run("ADC frame started with no command queued");
        note_owner(OWNER_ADC);
        dev_word = dev_word_q.pop_front();
        rsp_exp_q.push_back(predict_rsp(dev_word));
        adc_obs.sel = ~adc_pins.sen_n;
        adc_bit = 23;
        adc_sdout <= dev_word[23];
        adc_rises = 0;
        adc_len = 0;
      end
      if (!(&adc_pins.sen_n)) begin
        adc_len++;
        if (~adc_pins.sen_n !== adc_obs.sel) abort_run("ADC select changed within a frame");
        if (adc_pins.sclk && !adc_sclk_d) begin
          adc_cap = {adc_cap[22:0], adc_pins.sdata};
          adc_rises++;
        end
        if (!adc_pins.sclk && adc_sclk_d) begin
          adc_bit--;
          adc_sdout <= (adc_bit >= 0) ? dev_word[adc_bit] : 1'b0;
        end
      end else begin
        check_count("o_adc_pins.sclk idle", adc_pins.sclk, 0);
        if (adc_cs_d) begin
          // frame just closed
          check_count("ADC sclk rises", adc_rises, `MDOM_ADC_BITS);
          check_count("ADC sen low cycles", adc_len, ADC_LEN);
          adc_obs.word = adc_cap;
          if (adc_exp_q.size() == 0) abort_run("ADC frame with no expected command");
          check_adc_frame(adc_obs, predict_adc_frame(adc_exp_q.pop_front()));
        end
      end
      adc_cs_d   <= !(&adc_pins.sen_n);
      adc_sclk_d <= adc_pins.sclk;
    end
  end

  // DAC device models, one capture per bus
  always @(negedge lclk) begin
    if (lclk_rst) begin
      dac_cs_d   <= 1'b0;
      dac_sclk_d <= '1;
    end else begin
      if (dac_cs_d === 1'b0 && !(&dac_pins.nsync_n)) begin
        note_owner(OWNER_DAC);
        dac_len = 0;
        dac_obs.chip_sel = '0;
        for (int b = 0; b < `MDOM_N_DAC_BUS; b++) begin
          dac_obs.bus_sel[b] = !(&dac_pins.nsync_n[b]);
          dac_obs.chip_sel   = dac_obs.chip_sel | ~dac_pins.nsync_n[b];
          dac_falls[b] = 0;
        end
      end
      if (!(&dac_pins.nsync_n)) begin
        dac_len++;
        for (int b = 0; b < `MDOM_N_DAC_BUS; b++) begin
          if (!(&dac_pins.nsync_n[b]) && !dac_pins.sclk[b] && dac_sclk_d[b]) begin
            dac_cap[b] = {dac_cap[b][30:0], dac_pins.din[b]};
            dac_falls[b]++;
          end
        end
      end else begin
        check_count("o_dac_pins.sclk idle", dac_pins.sclk, 3'b111);
        if (dac_cs_d) begin
          check_count("DAC nsync low cycles", dac_len, DAC_LEN);
          if (dac_exp_q.size() == 0) abort_run("DAC frame with no expected command");
          for (int b = 0; b < `MDOM_N_DAC_BUS; b++) begin
            if (dac_obs.bus_sel[b]) begin
              check_count("DAC sclk falls", dac_falls[b], `MDOM_DAC_BITS);
              dac_obs.word = dac_cap[b];
              check_dac_frame(dac_obs, predict_dac_frame(dac_exp_q[0]));
            end
          end
          void'(dac_exp_q.pop_front());
        end
      end
      dac_cs_d   <= !(&dac_pins.nsync_n);
      dac_sclk_d <= dac_pins.sclk;
    end
  end

  // readback taken on the next rising edge
  always @(negedge lclk) begin
    if (!lclk_rst && adc_rsp_valid && adc_rsp_ready) begin
      if (rsp_exp_q.size() == 0) abort_run("readback with no ADC frame behind it");
      check_adc_rsp(adc_rsp, rsp_exp_q.pop_front());
    end
  end

  function automatic adc_cmd_t make_adc_cmd();
    adc_cmd_t c;
    c.sel  = 6'b1 << (take_bits(8) % `MDOM_N_ADC);
    c.word = take_bits(24);
    return c;
  endfunction

  function automatic dac_cmd_t make_dac_cmd();
    dac_cmd_t c;
    c.bus_sel  = 3'b1 << (take_bits(8) % `MDOM_N_DAC_BUS);
    c.chip_sel = 3'b1 << (take_bits(8) % `MDOM_N_DAC_CHIP);
    c.word     = take_bits(32);
    return c;
  endfunction

  // waits for the needed readies, then one valid cycle
  task automatic send_cmds(input logic do_adc, input logic do_dac);
    int n;
    for (n = 0; n < WAIT_LIMIT; n++) begin
      if ((!do_adc || adc_cmd_ready) && (!do_dac || dac_cmd_ready)) break;
      @(posedge lclk);
      #0.5;
    end
    if (n == WAIT_LIMIT) abort_run("timeout waiting for command ready");
    if (do_adc) begin
      adc_cmd = make_adc_cmd();
      adc_exp_q.push_back(adc_cmd);
      dev_word_q.push_back(take_bits(24));
      adc_cmd_valid = 1'b1;
    end
    if (do_dac) begin
      dac_cmd = make_dac_cmd();
      dac_exp_q.push_back(dac_cmd);
      dac_cmd_valid = 1'b1;
    end
    @(posedge lclk);
    #0.5;
    adc_cmd_valid = 1'b0;
    dac_cmd_valid = 1'b0;
  endtask

  task automatic wait_quiet();
    int n;
    for (n = 0; n < WAIT_LIMIT; n++) begin
      @(posedge lclk);
      #0.5;
      if (adc_exp_q.size() == 0 && dac_exp_q.size() == 0 && rsp_exp_q.size() == 0 &&
          dev_word_q.size() == 0 && !adc_cs_d && !dac_cs_d && !adc_rsp_valid) break;
    end
    if (n == WAIT_LIMIT) abort_run("timeout waiting for traffic to drain");
  endtask

  initial begin
    int n;
    lclk_rst      = 1'b1;
    adc_cmd_valid = 1'b0;
    adc_cmd       = '0;
    dac_cmd_valid = 1'b0;
    dac_cmd       = '0;
    adc_rsp_ready = 1'b1;
    adc_sdout     = 1'b0;
    check_order   = 1'b1;
    owner_seen    = 1'b0;
    hold_adc      = 1'b0;
    repeat (5) @(posedge lclk);
    #0.5;
    lclk_rst = 1'b0;
    // idle state after reset
    check_count("o_adc_cmd_ready", adc_cmd_ready, 1);
    check_count("o_dac_cmd_ready", dac_cmd_ready, 1);
    check_count("o_adc_rsp_valid", adc_rsp_valid, 0);
    // arbitration, both ports loaded together
    repeat (4) send_cmds(1'b1, 1'b1);
    wait_quiet();
    check_order = 1'b0;
    // single writes on each port
    repeat (3) begin
      send_cmds(1'b1, 1'b0);
      wait_quiet();
      send_cmds(1'b0, 1'b1);
      wait_quiet();
    end
    // readback held, DAC keeps going
    adc_rsp_ready = 1'b0;
    send_cmds(1'b1, 1'b0);
    for (n = 0; n < WAIT_LIMIT && !adc_rsp_valid; n++) begin
      @(posedge lclk);
      #0.5;
    end
    if (n == WAIT_LIMIT) abort_run("timeout waiting for ADC readback");
    hold_adc = 1'b1;
    // ADC queued ahead of the DAC so only the unread readback holds it back
    send_cmds(1'b1, 1'b0);
    send_cmds(1'b0, 1'b1);
    for (n = 0; n < WAIT_LIMIT && dac_exp_q.size() != 0; n++) begin
      @(posedge lclk);
      #0.5;
    end
    if (n == WAIT_LIMIT) abort_run("DAC frame blocked by unread readback");
    hold_adc = 1'b0;
    adc_rsp_ready = 1'b1;
    wait_quiet();
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
+incdir+include
hw/mdom_spi_pkg.sv
hw/spi_cmd_queue.sv
hw/spi_bus_arbiter.sv
hw/spi_shift_engine.sv
hw/mdom_slow_ctrl_top.sv
bench/mdom_spi_props.sv
bench/tb_mdom_slow_ctrl.sv

//--- hw/mdom_slow_ctrl_top.sv
// ------------------------------------------------------------
// slow-control SPI block for the six ADCs and three DAC banks
// commands in on valid/ready, ADC readback out on valid/ready
// ------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module mdom_slow_ctrl_top (
  input  wire logic                   i_lclk,
  input  wire logic                   i_lclk_rst,
  // ADC commands
  input  wire logic                   i_adc_cmd_valid,
  output logic                        o_adc_cmd_ready,
  input  wire mdom_spi_pkg::adc_cmd_t i_adc_cmd,
  // DAC commands
  input  wire logic                   i_dac_cmd_valid,
  output logic                        o_dac_cmd_ready,
  input  wire mdom_spi_pkg::dac_cmd_t i_dac_cmd,
  // ADC readback
  output logic                        o_adc_rsp_valid,
  input  wire logic                   i_adc_rsp_ready,
  output mdom_spi_pkg::adc_rsp_t      o_adc_rsp,
  // serial pins
  output mdom_spi_pkg::adc_pins_t     o_adc_pins,
  input  wire logic                   i_adc_sdout,
  output mdom_spi_pkg::dac_pins_t     o_dac_pins
);
  import mdom_spi_pkg::*;

  // queue to arbiter
  logic     adc_q_valid;
  logic     adc_q_ready;
  adc_cmd_t adc_q_cmd;
  logic     dac_q_valid;
  logic     dac_q_ready;
  dac_cmd_t dac_q_cmd;

  // arbiter to engine
  logic        job_start;
  spi_job_t    job;
  logic        eng_busy;
  logic        eng_done;
  logic [31:0] eng_rd_word;
  logic        eng_sclk;
  logic        eng_mosi;

  spi_cmd_queue #(.payload_t(adc_cmd_t)) u_adc_queue (
    .i_lclk     (i_lclk),
    .i_lclk_rst (i_lclk_rst),
    .i_valid    (i_adc_cmd_valid),
    .o_ready    (o_adc_cmd_ready),
    .i_data     (i_adc_cmd),
    .o_valid    (adc_q_valid),
    .i_ready    (adc_q_ready),
    .o_data     (adc_q_cmd)
  );

  spi_cmd_queue #(.payload_t(dac_cmd_t)) u_dac_queue (
    .i_lclk     (i_lclk),
    .i_lclk_rst (i_lclk_rst),
    .i_valid    (i_dac_cmd_valid),
    .o_ready    (o_dac_cmd_ready),
    .i_data     (i_dac_cmd),
    .o_valid    (dac_q_valid),
    .i_ready    (dac_q_ready),
    .o_data     (dac_q_cmd)
  );

  spi_bus_arbiter u_arbiter (
    .i_lclk          (i_lclk),
    .i_lclk_rst      (i_lclk_rst),
    .i_adc_valid     (adc_q_valid),
    .o_adc_ready     (adc_q_ready),
    .i_adc_cmd       (adc_q_cmd),
    .i_dac_valid     (dac_q_valid),
    .o_dac_ready     (dac_q_ready),
    .i_dac_cmd       (dac_q_cmd),
    .o_job_start     (job_start),
    .o_job           (job),
    .i_eng_busy      (eng_busy),
    .i_eng_done      (eng_done),
    .i_eng_rd_word   (eng_rd_word),
    .i_eng_sclk      (eng_sclk),
    .i_eng_mosi      (eng_mosi),
    .o_adc_pins      (o_adc_pins),
    .o_dac_pins      (o_dac_pins),
    .o_adc_rsp_valid (o_adc_rsp_valid),
    .i_adc_rsp_ready (i_adc_rsp_ready),
    .o_adc_rsp       (o_adc_rsp)
  );

  // only the ADCs talk back
  spi_shift_engine u_engine (
    .i_lclk     (i_lclk),
    .i_lclk_rst (i_lclk_rst),
    .i_start    (job_start),
    .i_job      (job),
    .o_busy     (eng_busy),
    .o_done     (eng_done),
    .o_rd_word  (eng_rd_word),
    .o_sclk     (eng_sclk),
    .o_mosi     (eng_mosi),
    .i_miso     (i_adc_sdout)
  );

endmodule

`default_nettype wire

//--- hw/mdom_spi_pkg.sv
// ------------------------------------------------------------
// command, job, response and pin types of the slow-control SPI
// import into any block that handles these bundles
// ------------------------------------------------------------
`default_nettype none

`include "mdom_spi_defs.svh"

package mdom_spi_pkg;

  // ADC register write, one-hot chip select
  typedef struct packed {
    logic [`MDOM_N_ADC-1:0]    sel;
    logic [`MDOM_ADC_BITS-1:0] word;
  } adc_cmd_t;

  // DAC write, one-hot bus and one-hot chip on that bus
  typedef struct packed {
    logic [`MDOM_N_DAC_BUS-1:0]  bus_sel;
    logic [`MDOM_N_DAC_CHIP-1:0] chip_sel;
    logic [`MDOM_DAC_BITS-1:0]   word;
  } dac_cmd_t;

  // low byte of the sampled ADC word
  typedef struct packed {
    logic [`MDOM_ADC_RD_BITS-1:0] rd_byte;
  } adc_rsp_t;

  // one frame for the shift engine, word is left aligned
  typedef struct packed {
    logic [5:0]                nbits;
    logic                      sclk_idle;
    logic [`MDOM_DAC_BITS-1:0] word;
  } spi_job_t;

  typedef enum logic {
    OWNER_ADC = 1'b0,
    OWNER_DAC = 1'b1
  } spi_owner_e;

  // shared ADC serial bus, sen active low
  typedef struct packed {
    logic                   sclk;
    logic                   sdata;
    logic [`MDOM_N_ADC-1:0] sen_n;
  } adc_pins_t;

  // nsync indexed [bus][chip], active low
  typedef struct packed {
    logic [`MDOM_N_DAC_BUS-1:0]                            sclk;
    logic [`MDOM_N_DAC_BUS-1:0]                            din;
    logic [`MDOM_N_DAC_BUS-1:0][`MDOM_N_DAC_CHIP-1:0]     nsync_n;
  } dac_pins_t;

endpackage

`default_nettype wire

//--- hw/spi_bus_arbiter.sv
// ------------------------------------------------------------
// shares the shift engine between the ADC and DAC clients
// round-robin grant, job build, pin routing and ADC readback
// ------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "mdom_spi_defs.svh"

module spi_bus_arbiter (
  input  wire logic                   i_lclk,
  input  wire logic                   i_lclk_rst,
  input  wire logic                   i_adc_valid,
  output logic                        o_adc_ready,
  input  wire mdom_spi_pkg::adc_cmd_t i_adc_cmd,
  input  wire logic                   i_dac_valid,
  output logic                        o_dac_ready,
  input  wire mdom_spi_pkg::dac_cmd_t i_dac_cmd,
  output logic                        o_job_start,
  output mdom_spi_pkg::spi_job_t      o_job,
  input  wire logic                   i_eng_busy,
  input  wire logic                   i_eng_done,
  input  wire logic [31:0]            i_eng_rd_word,
  input  wire logic                   i_eng_sclk,
  input  wire logic                   i_eng_mosi,
  output mdom_spi_pkg::adc_pins_t     o_adc_pins,
  output mdom_spi_pkg::dac_pins_t     o_dac_pins,
  output logic                        o_adc_rsp_valid,
  input  wire logic                   i_adc_rsp_ready,
  output mdom_spi_pkg::adc_rsp_t      o_adc_rsp
);
  import mdom_spi_pkg::*;

  logic                         active_q;
  logic                         start_q;
  spi_owner_e                   owner_q;
  spi_owner_e                   rr_q;
  logic [`MDOM_N_ADC-1:0]       adc_sel_q;
  logic [`MDOM_N_DAC_BUS-1:0]   dac_bus_q;
  logic [`MDOM_N_DAC_CHIP-1:0]  dac_chip_q;
  spi_job_t                     job_q;
  spi_job_t                     adc_job;
  spi_job_t                     dac_job;
  logic                         rsp_valid_q;
  adc_rsp_t                     rsp_q;
  logic                         can_grant;
  logic                         adc_elig;
  logic                         pick_adc;
  logic                         grant_adc;
  logic                         grant_dac;
  logic                         cs_adc;
  logic                         cs_dac;
  logic                         route_adc;
  logic                         route_dac;

  // ADC held back while its readback is unread
  assign adc_elig  = i_adc_valid && !rsp_valid_q;
  assign can_grant = !active_q && !i_eng_busy;
  // pointer only matters when both want the bus
  assign pick_adc  = adc_elig && (!i_dac_valid || rr_q == OWNER_ADC);
  assign grant_adc = can_grant && pick_adc;
  assign grant_dac = can_grant && i_dac_valid && !pick_adc;

  assign o_adc_ready = grant_adc;
  assign o_dac_ready = grant_dac;

  // ADC word padded below so the MSB leads
  assign adc_job.nbits     = 6'(`MDOM_ADC_BITS);
  assign adc_job.sclk_idle = 1'b0;
  assign adc_job.word      = {i_adc_cmd.word, {(`MDOM_DAC_BITS - `MDOM_ADC_BITS){1'b0}}};
  // DAC clock idles high
  assign dac_job.nbits     = 6'(`MDOM_DAC_BITS);
  assign dac_job.sclk_idle = 1'b1;
  assign dac_job.word      = i_dac_cmd.word;

  always_ff @(posedge i_lclk) begin
    if (i_lclk_rst) begin
      active_q   <= 1'b0;
      start_q    <= 1'b0;
      owner_q    <= OWNER_ADC;
      rr_q       <= OWNER_ADC;
      adc_sel_q  <= '0;
      dac_bus_q  <= '0;
      dac_chip_q <= '0;
    end else begin
      start_q <= grant_adc || grant_dac;
      if (grant_adc) begin
        active_q  <= 1'b1;
        owner_q   <= OWNER_ADC;
        rr_q      <= OWNER_DAC;
        adc_sel_q <= i_adc_cmd.sel;
      end else if (grant_dac) begin
        active_q   <= 1'b1;
        owner_q    <= OWNER_DAC;
        rr_q       <= OWNER_ADC;
        dac_bus_q  <= i_dac_cmd.bus_sel;
        dac_chip_q <= i_dac_cmd.chip_sel;
      end else if (i_eng_done) begin
        // frame over, bus free next cycle
        active_q <= 1'b0;
      end
    end
  end

  // job payload
  always_ff @(posedge i_lclk) begin
    if (grant_adc) begin
      job_q <= adc_job;
    end else if (grant_dac) begin
      job_q <= dac_job;
    end
  end

  assign o_job_start = start_q;
  assign o_job       = job_q;

  // readback register, set on an ADC done
  always_ff @(posedge i_lclk) begin
    if (i_lclk_rst) begin
      rsp_valid_q <= 1'b0;
    end else if (i_eng_done && owner_q == OWNER_ADC) begin
      rsp_valid_q <= 1'b1;
    end else if (i_adc_rsp_ready) begin
      rsp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge i_lclk) begin
    if (i_eng_done && owner_q == OWNER_ADC) begin
      rsp_q.rd_byte <= i_eng_rd_word[`MDOM_ADC_RD_BITS-1:0];
    end
  end

  assign o_adc_rsp_valid = rsp_valid_q;
  assign o_adc_rsp       = rsp_q;

  // chip select from start cycle until the done cycle
  assign cs_adc = active_q && !i_eng_done && owner_q == OWNER_ADC;
  assign cs_dac = active_q && !i_eng_done && owner_q == OWNER_DAC;
  // clock and data only once the engine holds the job
  assign route_adc = active_q && i_eng_busy && owner_q == OWNER_ADC;
  assign route_dac = active_q && i_eng_busy && owner_q == OWNER_DAC;

  assign o_adc_pins.sclk  = route_adc ? i_eng_sclk : 1'b0;
  assign o_adc_pins.sdata = route_adc ? i_eng_mosi : 1'b0;
  assign o_adc_pins.sen_n = ~(adc_sel_q & {`MDOM_N_ADC{cs_adc}});

  // unselected buses park sclk high, din low
  always_comb begin
    for (int b = 0; b < `MDOM_N_DAC_BUS; b++) begin
      o_dac_pins.sclk[b]    = (route_dac && dac_bus_q[b]) ? i_eng_sclk : 1'b1;
      o_dac_pins.din[b]     = (route_dac && dac_bus_q[b]) ? i_eng_mosi : 1'b0;
      o_dac_pins.nsync_n[b] = ~(dac_chip_q & {`MDOM_N_DAC_CHIP{cs_dac && dac_bus_q[b]}});
    end
  end

endmodule

`default_nettype wire

//--- hw/spi_cmd_queue.sv
// ------------------------------------------------------------
// single-entry valid/ready holding register for one command
// one instance per client, payload chosen by type parameter
// ------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module spi_cmd_queue #(
  parameter type payload_t = mdom_spi_pkg::adc_cmd_t
) (
  input  wire logic     i_lclk,
  input  wire logic     i_lclk_rst,
  // outside side
  input  wire logic     i_valid,
  output logic          o_ready,
  input  wire payload_t i_data,
  // arbiter side
  output logic          o_valid,
  input  wire logic     i_ready,
  output payload_t      o_data
);

  logic     full_q;
  payload_t data_q;

  // occupancy, one command at a time
  always_ff @(posedge i_lclk) begin
    if (i_lclk_rst) begin
      full_q <= 1'b0;
    end else if (!full_q && i_valid) begin
      full_q <= 1'b1;
    end else if (full_q && i_ready) begin
      // arbiter took it
      full_q <= 1'b0;
    end
  end

  // payload captured only on acceptance
  always_ff @(posedge i_lclk) begin
    if (!full_q && i_valid) begin
      data_q <= i_data;
    end
  end

  // empty means ready, so at most one accept every two cycles
  assign o_ready = !full_q;
  assign o_valid = full_q;
  assign o_data  = data_q;

endmodule

`default_nettype wire

//--- hw/spi_shift_engine.sv
// ------------------------------------------------------------
// timed serial shifter shared by both SPI ports
// start with a job while idle, done pulses as chip select drops
// ------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "mdom_spi_defs.svh"

module spi_shift_engine (
  input  wire logic                   i_lclk,
  input  wire logic                   i_lclk_rst,
  input  wire logic                   i_start,
  input  wire mdom_spi_pkg::spi_job_t i_job,
  output logic                        o_busy,
  output logic                        o_done,
  output logic [31:0]                 o_rd_word,
  output logic                        o_sclk,
  output logic                        o_mosi,
  input  wire logic                   i_miso
);
  import mdom_spi_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_LEAD,
    ST_SHIFT,
    ST_TAIL
  } eng_state_e;

  eng_state_e                state_q;
  logic [7:0]                tmr_q;
  logic [5:0]                bits_q;
  logic                      half_q;
  logic                      idle_q;
  logic                      sclk_q;
  logic                      done_q;
  logic [`MDOM_DAC_BITS-1:0] sh_q;
  logic [`MDOM_DAC_BITS-1:0] rd_q;
  spi_job_t                  job;
  logic                      first_edge;
  logic                      second_edge;

  assign job = i_job;

  // sclk leaves idle, device and engine sample here
  assign first_edge = tmr_q == 8'd0 &&
                      (state_q == ST_LEAD ||
                       (state_q == ST_SHIFT && half_q && bits_q != 6'd1));
  // sclk back to idle, mosi advances here
  assign second_edge = state_q == ST_SHIFT && tmr_q == 8'd0 && !half_q;

  always_ff @(posedge i_lclk) begin
    if (i_lclk_rst) begin
      state_q <= ST_IDLE;
      tmr_q   <= '0;
      bits_q  <= '0;
      half_q  <= 1'b0;
      idle_q  <= 1'b0;
      sclk_q  <= 1'b0;
      done_q  <= 1'b0;
      sh_q    <= '0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (i_start) begin
            // start cycle counts as the first lead cycle
            state_q <= ST_LEAD;
            tmr_q   <= 8'(`MDOM_SPI_LEAD - 2);
            bits_q  <= job.nbits;
            idle_q  <= job.sclk_idle;
            sclk_q  <= job.sclk_idle;
            sh_q    <= job.word;
          end
        end
        ST_LEAD: begin
          if (first_edge) begin
            state_q <= ST_SHIFT;
            tmr_q   <= 8'(`MDOM_SPI_HALF - 1);
            half_q  <= 1'b0;
            sclk_q  <= ~idle_q;
          end else begin
            tmr_q <= tmr_q - 8'd1;
          end
        end
        ST_SHIFT: begin
          if (tmr_q != 8'd0) begin
            tmr_q <= tmr_q - 8'd1;
          end else if (second_edge) begin
            sclk_q <= idle_q;
            sh_q   <= sh_q << 1;
            half_q <= 1'b1;
            tmr_q  <= 8'(`MDOM_SPI_HALF - 1);
          end else if (first_edge) begin
            sclk_q <= ~idle_q;
            half_q <= 1'b0;
            bits_q <= bits_q - 6'd1;
            tmr_q  <= 8'(`MDOM_SPI_HALF - 1);
          end else begin
            // last period finished, hold chip select
            state_q <= ST_TAIL;
            tmr_q   <= 8'(`MDOM_SPI_TAIL - 1);
          end
        end
        ST_TAIL: begin
          if (tmr_q == 8'd0) begin
            state_q <= ST_IDLE;
            done_q  <= 1'b1;
          end else begin
            tmr_q <= tmr_q - 8'd1;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // miso shifts in LSB side, last bits land in the low byte
  always_ff @(posedge i_lclk) begin
    if (state_q == ST_IDLE && i_start) begin
      rd_q <= '0;
    end else if (first_edge) begin
      rd_q <= {rd_q[`MDOM_DAC_BITS-2:0], i_miso};
    end
  end

  assign o_busy    = state_q != ST_IDLE;
  assign o_done    = done_q;
  assign o_rd_word = rd_q;
  assign o_sclk    = sclk_q;
  // MSB first
  assign o_mosi    = sh_q[`MDOM_DAC_BITS-1];

endmodule

`default_nettype wire

//--- include/mdom_spi_defs.svh
// ------------------------------------------------------------
// sizes and serial timing for the mainboard slow-control SPI
// include wherever frame lengths or select widths are needed
// ------------------------------------------------------------
`ifndef MDOM_SPI_DEFS_SVH
`define MDOM_SPI_DEFS_SVH

// chip counts
`define MDOM_N_ADC 6
`define MDOM_N_DAC_BUS 3
`define MDOM_N_DAC_CHIP 3

// frame lengths in bits
`define MDOM_ADC_BITS 24
// also the width of the engine shift register
`define MDOM_DAC_BITS 32
// readback byte from the ADC
`define MDOM_ADC_RD_BITS 8

// serial timing in lclk cycles
// chip select to first sclk edge
`define MDOM_SPI_LEAD 4
// half period of sclk
`define MDOM_SPI_HALF 2
// last edge to chip select release
`define MDOM_SPI_TAIL 4

`endif
